// File: include/cfg_defines.svh
`ifndef CFG_DEFINES_SVH
`define CFG_DEFINES_SVH

// reset chain
`define CFG_NSTEP         4     // board reset steps
`define CFG_RST_LEN       16    // pulse length per step, clk200 cycles
`define CFG_STEP_TIMEOUT  200   // cycles allowed for done after pulse falls

// mdio
`define CFG_PREAMBLE      32    // preamble ones before each frame
`define CFG_MDC_DIV_RST   8'd4  // mdc half period out of reset

// local bus register map
`define CFG_ADDR_STATUS    8'h00
`define CFG_ADDR_MDIO_CTRL 8'h01
`define CFG_ADDR_MDIO_DATA 8'h02
`define CFG_ADDR_HWRESET   8'h03
`define CFG_ADDR_MDC_DIV   8'h04

// status word layout
`define CFG_STAT_ERR_LSB   8    // error flags start here

`endif

// File: rtl/cfg_pkg.sv
package cfg_pkg;

	// local bus opcode
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} cfg_op_e;

	// one strobed command, 41 bits
	typedef struct packed {
		cfg_op_e     op;
		logic [7:0]  addr;
		logic [31:0] data;
	} lb_cmd_t;

	// clause-22 opcode field values
	typedef enum logic [1:0] {
		MDIO_WRITE = 2'b01,
		MDIO_READ  = 2'b10
	} mdio_op_e;

	// matches MDIO_CTRL write data [27:0], op on top
	typedef struct packed {
		mdio_op_e    op;
		logic [4:0]  phy;
		logic [4:0]  reg_addr;
		logic [15:0] wdata;      // ignored on reads
	} mdio_req_t;

	// reset sequencer
	typedef enum logic [1:0] {
		CH_IDLE,       // resting, or armed to start step 0
		CH_PULSE,      // step_reset high for the current step
		CH_WAIT_DONE,  // pulse over, timeout running
		CH_FAULT       // step never reported done
	} chain_state_e;

	typedef enum logic [1:0] {
		MD_IDLE,
		MD_PREAMBLE,
		MD_FRAME
	} mdio_state_e;

endpackage

// File: rtl/cfg_regs.sv
`timescale 1ns/10ps
`include "cfg_defines.svh"

module cfg_regs (
	input  logic                  clk200,
	input  logic                  rst_n,
	input  cfg_pkg::lb_cmd_t      lb_cmd,
	input  logic                  lb_strobe,
	output logic [31:0]           lb_rdata,
	output logic                  lb_rvalid,   // one cycle after a read strobe
	output logic                  chain_restart,
	input  logic [`CFG_NSTEP-1:0] step_done_flags,
	input  logic [`CFG_NSTEP-1:0] step_err_flags,
	output logic                  mdio_start,
	output cfg_pkg::mdio_req_t    mdio_req,
	output logic [7:0]            mdc_div,
	input  logic                  mdio_busy,
	input  logic [15:0]           mdio_rdata
);
	logic        wr;
	logic        rd;
	logic [31:0] rd_word;  // selected read source

	assign wr = lb_strobe && (lb_cmd.op == cfg_pkg::OP_WRITE);
	assign rd = lb_strobe && (lb_cmd.op == cfg_pkg::OP_READ);

	// read mux, unmapped and write-only addresses give 0
	always_comb begin
		rd_word = '0;
		case (lb_cmd.addr)
			`CFG_ADDR_STATUS: begin
				rd_word[`CFG_NSTEP-1:0]                 = step_done_flags;
				rd_word[`CFG_STAT_ERR_LSB +: `CFG_NSTEP] = step_err_flags;
			end
			`CFG_ADDR_MDIO_DATA: rd_word = {15'h0, mdio_busy, mdio_rdata};
			`CFG_ADDR_MDC_DIV:   rd_word = {24'h0, mdc_div};
			default:             rd_word = '0;
		endcase
	end

	always_ff @(posedge clk200 or negedge rst_n) begin
		if (!rst_n) begin
			lb_rvalid     <= 1'b0;
			chain_restart <= 1'b0;
			mdio_start    <= 1'b0;
			mdc_div       <= `CFG_MDC_DIV_RST;
		end else begin
			lb_rvalid     <= rd;
			chain_restart <= wr && (lb_cmd.addr == `CFG_ADDR_HWRESET); // data ignored
			mdio_start    <= wr && (lb_cmd.addr == `CFG_ADDR_MDIO_CTRL);
			if (wr && (lb_cmd.addr == `CFG_ADDR_MDC_DIV))
				mdc_div <= lb_cmd.data[7:0];
		end
	end

	// request and read data, valid alongside start and rvalid
	always_ff @(posedge clk200) begin
		if (wr && (lb_cmd.addr == `CFG_ADDR_MDIO_CTRL))
			mdio_req <= cfg_pkg::mdio_req_t'(lb_cmd.data[27:0]);
		if (rd)
			lb_rdata <= rd_word;
	end

endmodule

// File: rtl/cfg_top.sv
`timescale 1ns/10ps
`include "cfg_defines.svh"

module cfg_top (
	input  logic                  clk200,
	input  logic                  rst_n,
	input  cfg_pkg::lb_cmd_t      lb_cmd,
	input  logic                  lb_strobe,
	output logic [31:0]           lb_rdata,
	output logic                  lb_rvalid,
	output logic [`CFG_NSTEP-1:0] step_reset,
	input  logic [`CFG_NSTEP-1:0] step_done,
	output logic                  mdc,
	output logic                  mdio_o,
	output logic                  mdio_oe,  // high while we drive the line
	input  logic                  mdio_i
);
	logic                  chain_restart;
	logic [`CFG_NSTEP-1:0] step_done_flags;
	logic [`CFG_NSTEP-1:0] step_err_flags;
	logic                  mdio_start;
	cfg_pkg::mdio_req_t    mdio_req;
	logic [7:0]            mdc_div;
	logic                  mdio_busy;
	logic [15:0]           mdio_rdata;

	// bus side, sole master of both engines
	cfg_regs cfg_regs_i (
		.clk200, .rst_n, .lb_cmd, .lb_strobe, .lb_rdata, .lb_rvalid,
		.chain_restart, .step_done_flags, .step_err_flags,
		.mdio_start, .mdio_req, .mdc_div, .mdio_busy, .mdio_rdata
	);

	reset_chain reset_chain_i (
		.clk200, .rst_n, .chain_restart, .step_done,
		.step_reset, .step_done_flags, .step_err_flags
	);

	mdio_master mdio_master_i (
		.clk200, .rst_n, .mdio_start, .mdio_req, .mdc_div,
		.mdio_busy, .mdio_rdata, .mdc, .mdio_o, .mdio_oe, .mdio_i
	);

endmodule

// File: rtl/mdio_master.sv
`timescale 1ns/10ps
`include "cfg_defines.svh"

module mdio_master (
	input  logic               clk200,
	input  logic               rst_n,
	input  logic               mdio_start,  // ignored while busy
	input  cfg_pkg::mdio_req_t mdio_req,
	input  logic [7:0]         mdc_div,     // mdc half period in clk200 cycles
	output logic               mdio_busy,
	output logic [15:0]        mdio_rdata,  // last read result
	output logic               mdc,
	output logic               mdio_o,
	output logic               mdio_oe,
	input  logic               mdio_i
);
	localparam logic [5:0] PRE_LAST   = 6'(`CFG_PREAMBLE - 1);
	localparam logic [5:0] FRAME_LAST = 6'd31;
	localparam logic [5:0] TA_PREV    = 6'd13; // last register address bit
	localparam logic [5:0] DATA_FIRST = 6'd16;

	cfg_pkg::mdio_state_e state;
	logic [7:0]  half;
	logic [7:0]  div_cnt;
	logic        tick;      // mdc toggles on this edge
	logic        rise;
	logic        fall_d;    // one cycle after mdc fell
	logic [5:0]  bit_cnt;   // preamble or frame bit index
	logic [5:0]  cur_bit;
	logic [31:0] shreg;     // frame, msb goes out first
	logic        rd_op;
	logic        load;
	logic        pre_end;
	logic        frame_end;
	logic        shift;

	assign half      = (mdc_div == 8'd0) ? 8'd1 : mdc_div;
	assign tick      = (state != cfg_pkg::MD_IDLE) && (div_cnt >= half - 8'd1);
	assign rise      = tick && !mdc;
	assign load      = mdio_start && (state == cfg_pkg::MD_IDLE);
	assign pre_end   = fall_d && (state == cfg_pkg::MD_PREAMBLE) && (bit_cnt == PRE_LAST);
	assign frame_end = fall_d && (state == cfg_pkg::MD_FRAME) && (bit_cnt == FRAME_LAST);
	assign shift     = pre_end || (fall_d && (state == cfg_pkg::MD_FRAME) && !frame_end);
	assign mdio_busy = (state != cfg_pkg::MD_IDLE);

	// with a divider of 1 the shift and the next rise share an edge
	assign cur_bit = fall_d ? bit_cnt + 6'd1 : bit_cnt;

	always_ff @(posedge clk200 or negedge rst_n) begin
		if (!rst_n) begin
			state      <= cfg_pkg::MD_IDLE;
			div_cnt    <= '0;
			mdc        <= 1'b0;
			fall_d     <= 1'b0;
			bit_cnt    <= '0;
			mdio_oe    <= 1'b0;
			mdio_rdata <= '0;
		end else begin
			fall_d <= tick && mdc;
			if (tick) begin
				div_cnt <= '0;
				mdc     <= ~mdc;
			end else if (state != cfg_pkg::MD_IDLE) begin
				div_cnt <= div_cnt + 8'd1;
			end
			// phy data valid around the rising edge
			if (rise && rd_op && (state == cfg_pkg::MD_FRAME) && !frame_end &&
					(cur_bit >= DATA_FIRST))
				mdio_rdata <= {mdio_rdata[14:0], mdio_i};
			case (state)
				cfg_pkg::MD_IDLE: begin
					if (mdio_start) begin
						state   <= cfg_pkg::MD_PREAMBLE;
						bit_cnt <= '0;
						div_cnt <= '0;
						mdio_oe <= 1'b1; // drive the preamble ones
					end
				end
				cfg_pkg::MD_PREAMBLE: begin
					if (pre_end) begin
						state   <= cfg_pkg::MD_FRAME;
						bit_cnt <= '0;
					end else if (fall_d) begin
						bit_cnt <= bit_cnt + 6'd1;
					end
				end
				cfg_pkg::MD_FRAME: begin
					if (frame_end) begin
						state   <= cfg_pkg::MD_IDLE;
						mdio_oe <= 1'b0;
						mdc     <= 1'b0; // park mdc low
						div_cnt <= '0;
					end else if (fall_d) begin
						bit_cnt <= bit_cnt + 6'd1;
						if (rd_op && (bit_cnt == TA_PREV))
							mdio_oe <= 1'b0; // phy owns the line from turnaround
					end
				end
				default: state <= cfg_pkg::MD_IDLE;
			endcase
		end
	end

	// frame shifter
	always_ff @(posedge clk200) begin
		if (load) begin
			rd_op  <= (mdio_req.op == cfg_pkg::MDIO_READ);
			mdio_o <= 1'b1;
			if (mdio_req.op == cfg_pkg::MDIO_READ)
				shreg <= {2'b01, mdio_req.op, mdio_req.phy, mdio_req.reg_addr, 18'h0};
			else
				shreg <= {2'b01, mdio_req.op, mdio_req.phy, mdio_req.reg_addr, 2'b10,
					mdio_req.wdata};
		end else if (shift) begin
			mdio_o <= shreg[31];
			shreg  <= {shreg[30:0], 1'b0};
		end else if (frame_end) begin
			mdio_o <= 1'b0;
		end
	end

endmodule

// File: rtl/reset_chain.sv
`timescale 1ns/10ps
`include "cfg_defines.svh"

module reset_chain (
	input  logic                  clk200,
	input  logic                  rst_n,
	input  logic                  chain_restart,   // one cycle pulse
	input  logic [`CFG_NSTEP-1:0] step_done,       // levels from the reset targets
	output logic [`CFG_NSTEP-1:0] step_reset,      // active high, never two at once
	output logic [`CFG_NSTEP-1:0] step_done_flags,
	output logic [`CFG_NSTEP-1:0] step_err_flags
);
	localparam int STEP_W  = (`CFG_NSTEP > 1) ? $clog2(`CFG_NSTEP) : 1;
	localparam int PULSE_W = $clog2(`CFG_RST_LEN + 1);
	localparam int TMO_W   = $clog2(`CFG_STEP_TIMEOUT + 1);
	localparam logic [STEP_W-1:0]  LAST_STEP  = STEP_W'(`CFG_NSTEP - 1);
	localparam logic [PULSE_W-1:0] PULSE_LAST = PULSE_W'(`CFG_RST_LEN - 1);
	localparam logic [TMO_W-1:0]   TMO_LAST   = TMO_W'(`CFG_STEP_TIMEOUT - 1);

	cfg_pkg::chain_state_e state;
	logic [STEP_W-1:0]  step;       // step being run
	logic [STEP_W-1:0]  next_step;
	logic [PULSE_W-1:0] pulse_cnt;
	logic [TMO_W-1:0]   tmo_cnt;    // cycles spent waiting for done
	logic               arm;        // start step 0 from idle

	assign next_step = step + 1'b1;

	always_ff @(posedge clk200 or negedge rst_n) begin
		if (!rst_n) begin
			state           <= cfg_pkg::CH_IDLE;
			arm             <= 1'b1; // kicks off the chain right after reset
			step            <= '0;
			pulse_cnt       <= '0;
			tmo_cnt         <= '0;
			step_reset      <= '0;
			step_done_flags <= '0;
			step_err_flags  <= '0;
		end else if (chain_restart) begin
			// restart wins over anything in flight
			state           <= cfg_pkg::CH_IDLE;
			arm             <= 1'b1;
			step            <= '0;
			step_reset      <= '0;
			step_done_flags <= '0;
			step_err_flags  <= '0;
		end else begin
			case (state)
				cfg_pkg::CH_IDLE: begin
					if (arm) begin
						arm              <= 1'b0;
						step_reset[step] <= 1'b1;
						pulse_cnt        <= '0;
						state            <= cfg_pkg::CH_PULSE;
					end
				end
				cfg_pkg::CH_PULSE: begin
					pulse_cnt <= pulse_cnt + 1'b1;
					if (pulse_cnt == PULSE_LAST) begin // rst_len cycles high
						step_reset <= '0;
						tmo_cnt    <= '0;
						state      <= cfg_pkg::CH_WAIT_DONE;
					end
				end
				cfg_pkg::CH_WAIT_DONE: begin
					if (step_done[step]) begin
						step_done_flags[step] <= 1'b1;
						if (step == LAST_STEP) begin
							state <= cfg_pkg::CH_IDLE; // chain complete, arm stays low
						end else begin
							step                  <= next_step;
							step_reset[next_step] <= 1'b1; // next pulse, no gap
							pulse_cnt             <= '0;
							state                 <= cfg_pkg::CH_PULSE;
						end
					end else if (tmo_cnt == TMO_LAST) begin
						step_err_flags[step] <= 1'b1;
						state                <= cfg_pkg::CH_FAULT;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				cfg_pkg::CH_FAULT: ; // parked until restart
				default: state <= cfg_pkg::CH_IDLE;
			endcase
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cfg_top testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cfg_top \
	-Mdir obj_dir -o tb_cfg_top -f src.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_cfg_top > "$log" 2>&1
rc=$?
cat "$log"
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi
if grep -q "Done: errors found" "$log"; then
	exit 1
fi
exit 0

// File: src.f
+incdir+include
rtl/cfg_pkg.sv
rtl/reset_chain.sv
rtl/mdio_master.sv
rtl/cfg_regs.sv
rtl/cfg_top.sv
verif/cfg_asserts.sv
verif/tb_cfg_top.sv

// File: verif/cfg_asserts.sv
`timescale 1ns/10ps
`include "cfg_defines.svh"

module cfg_asserts (
	input logic                  clk200,
	input logic                  rst_n,
	input cfg_pkg::lb_cmd_t      lb_cmd,
	input logic                  lb_strobe,
	input logic                  lb_rvalid,
	input logic [`CFG_NSTEP-1:0] step_reset,
	input logic                  mdio_busy,   // internal to cfg_top
	input logic                  mdio_oe
);
	// steps reset strictly one at a time
	a_one_reset: assert property (@(posedge clk200) disable iff (!rst_n)
		$onehot0(step_reset))
		else $error("more than one step_reset high: %b", step_reset);

	a_rvalid_after_read: assert property (@(posedge clk200) disable iff (!rst_n)
		lb_rvalid |-> $past(lb_strobe && (lb_cmd.op == cfg_pkg::OP_READ)))
		else $error("lb_rvalid without a read strobe the cycle before");

	// line released whenever the master is idle
	a_oe_idle: assert property (@(posedge clk200) disable iff (!rst_n)
		!mdio_busy |-> !mdio_oe)
		else $error("mdio_oe high while mdio master idle");

endmodule

bind cfg_top cfg_asserts cfg_asserts_i (.*);

// File: verif/tb_cfg_top.sv
`timescale 1ns/10ps
`include "cfg_defines.svh"

module tb_cfg_top;
	localparam int CHAIN_CYC = 3 * `CFG_NSTEP * (`CFG_RST_LEN + `CFG_STEP_TIMEOUT); // three runs
	localparam int FRAME_CYC = (`CFG_PREAMBLE + 32) * 2 * int'(`CFG_MDC_DIV_RST);
	localparam int WD_CYC    = 16 + CHAIN_CYC + 2 * FRAME_CYC + 2000; // plus bus margin

	logic                  clk200;
	logic                  rst_n;
	cfg_pkg::lb_cmd_t      lb_cmd;
	logic                  lb_strobe;
	logic [31:0]           lb_rdata;
	logic                  lb_rvalid;
	logic [`CFG_NSTEP-1:0] step_reset;
	logic [`CFG_NSTEP-1:0] step_done = '0;
	logic                  mdc;
	logic                  mdio_o;
	logic                  mdio_oe;
	logic                  mdio_i = 1'b1;   // pull-up level
	string                 cur_test;
	int                    err_cnt;
	int                    chk_cnt;
	int                    test_cnt;
	int                    test_err0;
	logic [`CFG_NSTEP-1:0] withhold = '0;   // steps that never report done
	logic [`CFG_NSTEP-1:0] rst_q = '0;
	int                    done_dly [`CFG_NSTEP];
	int                    hi_len [`CFG_NSTEP];
	int                    pulse_q[$];      // step index per finished pulse
	int                    len_q[$];
	int                    order_q[$];      // previous step done at pulse start
	logic                  mdc_q = 1'b0;
	int                    pre_ones = 0;
	int                    phy_cnt = 0;     // frame bits taken, 0 while hunting
	logic [31:0]           phy_sh;
	logic                  phy_rd = 1'b0;
	logic [15:0]           phy_word;        // read data of the current frame
	logic [15:0]           phy_tx;
	logic                  line;
	logic [31:0]           exp_q[$];
	logic [31:0]           mask_q[$];
	logic [31:0]           got_q[$];
	int                    frames_cmp = 0;

	cfg_top cfg_top_i (.*);

	initial begin
		clk200 = 1'b0;
		forever #50 clk200 = ~clk200;
	end

	// step targets plus a monitor on the pulses
	always @(posedge clk200) begin
		for (int s = 0; s < `CFG_NSTEP; s++) begin
			if (step_reset[s]) begin
				step_done[s] <= 1'b0; // done drops with the reset
				if (!rst_q[s]) begin
					done_dly[s] = 5 + int'($urandom % 26);
					hi_len[s]   = 0;
					order_q.push_back((s == 0) ? 1 : int'(step_done[s-1]));
				end
				hi_len[s]++;
			end else if (rst_q[s]) begin // pulse just ended
				pulse_q.push_back(s);
				len_q.push_back(hi_len[s]);
			end else if (done_dly[s] > 0 && !withhold[s]) begin
				done_dly[s]--;
				if (done_dly[s] == 0)
					step_done[s] <= 1'b1;
			end
		end
		rst_q <= step_reset;
	end

	assign line = mdio_oe ? mdio_o : mdio_i; // shared mdio wire

	// phy side, edges seen one clk late
	always @(posedge clk200) begin
		mdc_q <= mdc;
		if (mdc && !mdc_q) begin
			if (phy_cnt == 0) begin
				if (line) begin
					pre_ones <= pre_ones + 1;
				end else begin
					if (pre_ones >= `CFG_PREAMBLE) begin // start bit after preamble
						phy_cnt  <= 1;
						phy_sh   <= 32'h0;
						phy_rd   <= 1'b0;
						phy_word <= 16'($urandom);
					end
					pre_ones <= 0;
				end
			end else begin
				phy_sh  <= {phy_sh[30:0], line};
				phy_cnt <= (phy_cnt == 31) ? 0 : phy_cnt + 1;
				if (phy_cnt == 3) begin // opcode complete
					phy_rd <= ({phy_sh[0], line} == 2'b10);
					phy_tx <= phy_word;
				end
				if (phy_cnt == 31)
					got_q.push_back({phy_sh[30:0], line});
			end
		end else if (!mdc && mdc_q) begin
			if (phy_rd && phy_cnt >= 16) begin
				mdio_i <= phy_tx[15]; // msb first
				phy_tx <= {phy_tx[14:0], 1'b0};
			end else begin
				mdio_i <= 1'b1;
			end
		end
	end

	// frame comparator
	always @(posedge clk200) begin : frame_cmp
		logic [31:0] got_f;
		logic [31:0] exp_f;
		logic [31:0] msk;
		if (got_q.size() != 0) begin
			got_f = got_q.pop_front();
			if (exp_q.size() == 0) begin
				$display("ERROR in %s: PHY saw an MDIO frame that was never requested",
					cur_test);
				err_cnt++;
			end else begin
				exp_f = exp_q.pop_front();
				msk   = mask_q.pop_front();
				check("mdio frame", exp_f & msk, got_f & msk);
				frames_cmp++;
			end
		end
	end

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("CHECK FAILED %s, %s: expected 0x%08h, actual 0x%08h", cur_test, what,
				exp, act);
		end
	endtask

	// clause-22 frame, start 01, op, phy, reg, turnaround, data
	function automatic logic [31:0] mdio_frame_ref(input cfg_pkg::mdio_req_t req);
		if (req.op == cfg_pkg::MDIO_READ)
			return {2'b01, 2'b10, req.phy, req.reg_addr, 18'h0}; // phy owns the rest
		return {2'b01, 2'b01, req.phy, req.reg_addr, 2'b10, req.wdata};
	endfunction

	// chain stops at the first withheld step
	function automatic logic [31:0] status_ref(input logic [`CFG_NSTEP-1:0] held);
		logic [31:0] st;
		st = '0;
		for (int s = 0; s < `CFG_NSTEP; s++) begin
			if (held[s]) begin
				st[8 + s] = 1'b1;
				return st;
			end
			st[s] = 1'b1;
		end
		return st;
	endfunction

	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk200);
		lb_cmd.op   <= cfg_pkg::OP_WRITE;
		lb_cmd.addr <= addr;
		lb_cmd.data <= data;
		lb_strobe   <= 1'b1;
		@(posedge clk200);
		lb_strobe   <= 1'b0;
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
		int lat;
		@(posedge clk200);
		lb_cmd.op   <= cfg_pkg::OP_READ;
		lb_cmd.addr <= addr;
		lb_cmd.data <= '0;
		lb_strobe   <= 1'b1;
		@(posedge clk200);
		lb_strobe <= 1'b0;
		lat = 0;
		while (!lb_rvalid && lat < 8) begin
			@(posedge clk200);
			lat++;
		end
		data = lb_rdata;
		if (!lb_rvalid) begin
			$display("ERROR in %s: no read response for address 0x%02h", cur_test, addr);
			err_cnt++;
		end
		check("rvalid latency", 1, lat);
	endtask

	// poll STATUS until all done or a step faulted
	task automatic wait_chain(output logic [31:0] st);
		int n;
		n = 0;
		do begin
			bus_read(`CFG_ADDR_STATUS, st);
			n++;
		end while (st[3:0] != 4'hF && st[11:8] == 4'h0 && n < CHAIN_CYC);
		if (st[3:0] != 4'hF && st[11:8] == 4'h0) begin
			$display("ERROR in %s: reset chain neither finished nor faulted", cur_test);
			err_cnt++;
		end
	endtask

	task automatic wait_mdio_idle(output logic [31:0] rd);
		int n;
		n = 0;
		do begin
			bus_read(`CFG_ADDR_MDIO_DATA, rd);
			n++;
		end while (rd[16] && n < FRAME_CYC);
		if (rd[16]) begin
			$display("ERROR in %s: MDIO master stayed busy", cur_test);
			err_cnt++;
		end
	endtask

	task automatic check_pulses(input int n);
		check("pulse starts", n, order_q.size()); // catches a pulse still in flight
		check("pulse count", n, pulse_q.size());
		for (int i = 0; i < pulse_q.size(); i++) begin
			check("pulse order", i, pulse_q[i]);
			check("pulse length", `CFG_RST_LEN, len_q[i]);
			check("pulse after previous done", 1, order_q[i]);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_err0 = err_cnt;
		pulse_q.delete();
		len_q.delete();
		order_q.delete();
	endtask

	task automatic end_test;
		test_cnt++;
		$display("test %0d %s: %s, %0d mismatches", test_cnt, cur_test,
			(err_cnt == test_err0) ? "ok" : "FAILED", err_cnt - test_err0);
	endtask

	initial begin : main
		cfg_pkg::mdio_req_t req;
		logic [31:0]        rd;
		logic [7:0]         div;
		int                 nf;
		void'($urandom(37));
		rst_n     = 1'b0;
		lb_strobe = 1'b0;
		lb_cmd    = '0;
		begin_test("power_on_chain");
		repeat (16) @(posedge clk200);
		rst_n <= 1'b1;
		wait_chain(rd);
		check_pulses(`CFG_NSTEP);
		check("status", status_ref('0), rd);
		end_test();

		begin_test("step_timeout");
		@(posedge clk200);
		withhold <= 4'b0100; // step 2 never done
		bus_write(`CFG_ADDR_HWRESET, 32'h0);
		wait_chain(rd);
		check_pulses(3); // nothing on step 3
		check("status", status_ref(4'b0100), rd);
		end_test();

		begin_test("restart");
		@(posedge clk200);
		withhold <= '0;
		bus_write(`CFG_ADDR_HWRESET, 32'hFFFF_FFFF); // data is don't care
		bus_read(`CFG_ADDR_STATUS, rd);
		check("flags cleared", 32'h0, rd);
		wait_chain(rd);
		check_pulses(`CFG_NSTEP);
		check("status", status_ref('0), rd);
		end_test();

		begin_test("mdio_write");
		req.op       = cfg_pkg::MDIO_WRITE;
		req.phy      = 5'($urandom);
		req.reg_addr = 5'($urandom);
		req.wdata    = 16'($urandom);
		exp_q.push_back(mdio_frame_ref(req));
		mask_q.push_back(32'hFFFF_FFFF);
		nf = frames_cmp;
		bus_write(`CFG_ADDR_MDIO_CTRL, {4'h0, req});
		bus_read(`CFG_ADDR_MDIO_DATA, rd);
		check("busy after start", 1, rd[16]);
		wait_mdio_idle(rd);
		check("frames seen at idle", nf + 1, frames_cmp);
		end_test();

		begin_test("mdio_read");
		req.op       = cfg_pkg::MDIO_READ;
		req.phy      = 5'($urandom);
		req.reg_addr = 5'($urandom);
		req.wdata    = '0;
		exp_q.push_back(mdio_frame_ref(req));
		mask_q.push_back(32'hFFFC_0000); // header bits only
		nf = frames_cmp;
		bus_write(`CFG_ADDR_MDIO_CTRL, {4'h0, req});
		wait_mdio_idle(rd);
		check("read data", {16'h0, phy_word}, {16'h0, rd[15:0]});
		check("frames seen at idle", nf + 1, frames_cmp);
		end_test();

		begin_test("register_access");
		div = 8'($urandom);
		bus_write(`CFG_ADDR_MDC_DIV, {24'($urandom), div}); // upper bits dropped
		bus_read(`CFG_ADDR_MDC_DIV, rd);
		check("mdc_div readback", {24'h0, div}, rd);
		bus_read(8'hA5, rd);
		check("unmapped read", 32'h0, rd);
		end_test();

		$display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin : watchdog
		#(WD_CYC * 100);
		$display("timeout: tests still running after %0d clock cycles", WD_CYC);
		$display("Done: errors found");
		$finish;
	end

endmodule
